//--- all.f
logic/exec_pkg.sv
logic/reg_file.sv
logic/operand_forward.sv
logic/alu.sv
logic/ex_stage.sv
logic/writeback_pipe.sv
logic/exec_core.sv
tests/exec_core_checker.sv
tests/exec_core_tb.sv

//--- logic/alu.sv
module alu import exec_pkg::*; (
	input exec_instr_s instr,
	input logic [data_w-1:0] a,
	input logic [data_w-1:0] b,
	input logic [data_w-1:0] spr,
	output wb_entry_s result
);

	logic [data_w-1:0] spr_next;

	assign spr_next = spr + sext_imm(instr.operand);

	always_comb begin
		result = '0;
		result.gr_valid = 1'b1;
		result.gr_dest = instr.dest;
		result.gr_dest_sysreg = instr.dest_sysreg;
		result.spr_data = spr_next;
		case (instr.opcode)
			op_add: result.gr_data = a + b;
			op_sub: result.gr_data = a - b;
			op_and: result.gr_data = a & b;
			op_or: result.gr_data = a | b;
			op_xor: result.gr_data = a ^ b;
			op_shl: result.gr_data = a << b[shamt_w-1:0];
			// Operand a already holds the system register value
			op_movs: result.gr_data = a;
			op_setsp: begin
				// GR side tagged as the SPR sysreg so it never matches a GR source
				result.gr_valid = 1'b0;
				result.spr_valid = 1'b1;
				result.gr_data = spr_next;
				result.gr_dest = sysreg_spr;
				result.gr_dest_sysreg = 1'b1;
			end
			// Unassigned opcodes retire as bubbles
			default: result.gr_valid = 1'b0;
		endcase
	end

endmodule

//--- logic/ex_stage.sv
module ex_stage import exec_pkg::*; (
	input logic clock,
	input logic arst_n,
	input logic issue_valid,
	input exec_instr_s issue_instr,
	input logic [data_w-1:0] rd_a_data,
	input logic [data_w-1:0] rd_b_data,
	input logic [data_w-1:0] rf_spr,
	input wb_entry_s wb,
	input wb_entry_s prev_wb,
	output logic [reg_addr_w-1:0] rd_a_ptr,
	output logic [reg_addr_w-1:0] rd_b_ptr,
	output wb_entry_s result
);

	logic ex_valid;
	exec_instr_s ex_instr;
	src_req_s src_a;
	src_req_s src_b;
	logic [data_w-1:0] op_a;
	logic [data_w-1:0] op_b;
	logic [data_w-1:0] fwd_spr;
	wb_entry_s alu_result;

	// Unimplemented system registers read as zero
	function automatic logic [data_w-1:0] sysreg_read(
		logic [reg_addr_w-1:0] ptr,
		logic [data_w-1:0] spr_value
	);
		return (ptr == sysreg_spr) ? spr_value : '0;
	endfunction

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			ex_valid <= 1'b0;
		end else begin
			ex_valid <= issue_valid;
		end
	end

	always_ff @(posedge clock) begin
		ex_instr <= issue_instr;
	end

	assign rd_a_ptr = ex_instr.a;
	assign rd_b_ptr = ex_instr.operand.reg_form.b;

	always_comb begin
		src_a.sysreg = ex_instr.a_sysreg;
		src_a.pointer = ex_instr.a;
		src_a.settle = 1'b0;
		src_a.data = ex_instr.a_sysreg ? sysreg_read(ex_instr.a, rf_spr) : rd_a_data;

		src_b.sysreg = ex_instr.operand.reg_form.b_sysreg;
		src_b.pointer = ex_instr.operand.reg_form.b;
		src_b.settle = 1'b0;
		src_b.data = src_b.sysreg ? sysreg_read(src_b.pointer, rf_spr) : rd_b_data;
		// Immediate form takes the same bits as a settled value
		if (ex_instr.use_imm) begin
			src_b.sysreg = 1'b0;
			src_b.settle = 1'b1;
			src_b.data = sext_imm(ex_instr.operand);
		end
	end

	operand_forward fwd_a (
		.src(src_a),
		.wb(wb),
		.prev_wb(prev_wb),
		.rf_spr(rf_spr),
		.data(op_a),
		.spr(fwd_spr)
	);

	// Same SPR view as fwd_a, so its spr output stays open
	operand_forward fwd_b (
		.src(src_b),
		.wb(wb),
		.prev_wb(prev_wb),
		.rf_spr(rf_spr),
		.data(op_b),
		.spr()
	);

	alu u_alu (
		.instr(ex_instr),
		.a(op_a),
		.b(op_b),
		.spr(fwd_spr),
		.result(alu_result)
	);

	always_comb begin
		result = alu_result;
		result.gr_valid = alu_result.gr_valid && ex_valid;
		result.spr_valid = alu_result.spr_valid && ex_valid;
	end

endmodule

//--- logic/exec_core.sv
module exec_core import exec_pkg::*; (
	input logic clock,
	input logic arst_n,
	input logic issue_valid,
	input exec_instr_s issue_instr,
	output wb_entry_s commit
);

	logic [reg_addr_w-1:0] rd_a_ptr;
	logic [reg_addr_w-1:0] rd_b_ptr;
	logic [data_w-1:0] rd_a_data;
	logic [data_w-1:0] rd_b_data;
	logic [data_w-1:0] rf_spr;
	wb_entry_s result;
	wb_entry_s wb;
	wb_entry_s prev_wb;

	ex_stage u_ex_stage (
		.clock(clock),
		.arst_n(arst_n),
		.issue_valid(issue_valid),
		.issue_instr(issue_instr),
		.rd_a_data(rd_a_data),
		.rd_b_data(rd_b_data),
		.rf_spr(rf_spr),
		.wb(wb),
		.prev_wb(prev_wb),
		.rd_a_ptr(rd_a_ptr),
		.rd_b_ptr(rd_b_ptr),
		.result(result)
	);

	writeback_pipe u_writeback_pipe (
		.clock(clock),
		.arst_n(arst_n),
		.result(result),
		.wb(wb),
		.prev_wb(prev_wb)
	);

	// Oldest stage retires into the register file
	reg_file u_reg_file (
		.clock(clock),
		.arst_n(arst_n),
		.rd_a_ptr(rd_a_ptr),
		.rd_b_ptr(rd_b_ptr),
		.wr(prev_wb),
		.rd_a_data(rd_a_data),
		.rd_b_data(rd_b_data),
		.spr(rf_spr)
	);

	assign commit = prev_wb;

endmodule

//--- logic/exec_pkg.sv
package exec_pkg;

	localparam int data_w = 32;
	localparam int reg_addr_w = 5;
	localparam int num_gr = 2 ** reg_addr_w;
	localparam int operand_w = 15;
	localparam int shamt_w = $clog2(data_w);

	// System register space, only SPR is implemented
	localparam logic [reg_addr_w-1:0] sysreg_spr = 5'd1;

	typedef enum logic [3:0] {
		op_add   = 4'd0,
		op_sub   = 4'd1,
		op_and   = 4'd2,
		op_or    = 4'd3,
		op_xor   = 4'd4,
		op_shl   = 4'd5,
		op_movs  = 4'd6,
		op_setsp = 4'd7
	} exec_op_e;

	// Register view of the operand field
	typedef struct packed {
		logic [reg_addr_w-1:0] b;
		logic b_sysreg;
		logic [8:0] pad;
	} exec_reg_form_s;

	typedef union packed {
		exec_reg_form_s reg_form;
		logic [operand_w-1:0] imm_form;
	} exec_operand_u;

	typedef struct packed {
		exec_op_e opcode;
		logic [reg_addr_w-1:0] dest;
		logic dest_sysreg;
		logic [reg_addr_w-1:0] a;
		logic a_sysreg;
		logic use_imm;
		exec_operand_u operand;
	} exec_instr_s;

	typedef struct packed {
		logic gr_valid;
		logic [data_w-1:0] gr_data;
		logic [reg_addr_w-1:0] gr_dest;
		logic gr_dest_sysreg;
		logic spr_valid;
		logic [data_w-1:0] spr_data;
	} wb_entry_s;

	typedef struct packed {
		logic sysreg;
		logic [reg_addr_w-1:0] pointer;
		logic settle;
		logic [data_w-1:0] data;
	} src_req_s;

	// Immediate view of the operand field, sign-extended to the datapath
	function automatic logic [data_w-1:0] sext_imm(exec_operand_u operand);
		return {{(data_w - operand_w){operand.imm_form[operand_w-1]}}, operand.imm_form};
	endfunction

endpackage

//--- logic/operand_forward.sv
module operand_forward import exec_pkg::*; (
	input src_req_s src,
	input wb_entry_s wb,
	input wb_entry_s prev_wb,
	input logic [data_w-1:0] rf_spr,
	output logic [data_w-1:0] data,
	output logic [data_w-1:0] spr
);

	logic [data_w-1:0] prev_data;

	// Correct one operand value from one writeback stage
	function automatic logic [data_w-1:0] forward_from(
		src_req_s req,
		wb_entry_s stage,
		logic [data_w-1:0] base
	);
		logic stage_valid;
		stage_valid = stage.gr_valid || stage.spr_valid;
		if (req.settle || !stage_valid) begin
			return base;
		end
		// SPR source picks up an SPR write
		if (req.sysreg && req.pointer == sysreg_spr && stage.spr_valid) begin
			return stage.spr_data;
		end
		// General source picks up a general write to the same pointer
		if (!req.sysreg && !stage.gr_dest_sysreg && req.pointer == stage.gr_dest) begin
			return stage.gr_data;
		end
		return base;
	endfunction

	// Older stage first, the younger one overrides it
	assign prev_data = forward_from(src, prev_wb, src.data);
	assign data = forward_from(src, wb, prev_data);

	always_comb begin
		if (wb.spr_valid) begin
			spr = wb.spr_data;
		end else if (prev_wb.spr_valid) begin
			spr = prev_wb.spr_data;
		end else begin
			spr = rf_spr;
		end
	end

endmodule

//--- logic/reg_file.sv
module reg_file import exec_pkg::*; (
	input logic clock,
	input logic arst_n,
	input logic [reg_addr_w-1:0] rd_a_ptr,
	input logic [reg_addr_w-1:0] rd_b_ptr,
	input wb_entry_s wr,
	output logic [data_w-1:0] rd_a_data,
	output logic [data_w-1:0] rd_b_data,
	output logic [data_w-1:0] spr
);

	logic [num_gr-1:0][data_w-1:0] gr;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			gr <= '0;
			spr <= '0;
		end else begin
			// A general result aimed at a system register is dropped
			if (wr.gr_valid && !wr.gr_dest_sysreg) begin
				gr[wr.gr_dest] <= wr.gr_data;
			end
			if (wr.spr_valid) begin
				spr <= wr.spr_data;
			end
		end
	end

	// Combinational reads, no bypass of the write in the same cycle
	assign rd_a_data = gr[rd_a_ptr];
	assign rd_b_data = gr[rd_b_ptr];

endmodule

//--- logic/writeback_pipe.sv
module writeback_pipe import exec_pkg::*; (
	input logic clock,
	input logic arst_n,
	input wb_entry_s result,
	output wb_entry_s wb,
	output wb_entry_s prev_wb
);

	// Shifts every cycle, no hold since there is no back-pressure
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			wb <= '0;
			prev_wb <= '0;
		end else begin
			wb <= result;
			prev_wb <= wb;
		end
	end

endmodule

//--- run.sh
#!/bin/sh
verilator --binary --timing -f all.f --top-module exec_core_tb -o sim \
	&& ./obj_dir/sim | tee /dev/stderr | grep -F -q '*** TEST PASSED ***' \
	|| { echo "simulation did not pass"; exit 1; }

//--- tests/exec_core_checker.sv
module exec_core_checker import exec_pkg::*; (
	input logic clock,
	input logic arst_n,
	input wb_entry_s wb,
	input wb_entry_s prev_wb
);
	timeunit 1ns;
	timeprecision 1ps;

	a_reset_clear: assert property (@(posedge clock)
		!arst_n |-> !(wb.gr_valid || wb.spr_valid || prev_wb.gr_valid || prev_wb.spr_valid))
		else $error("valid bit set in reset");

	// Older stage is the younger one delayed by a cycle
	a_shift: assert property (@(posedge clock) disable iff (!arst_n)
		$past(arst_n) |-> prev_wb == $past(wb))
		else $error("prev_wb differs from previous wb");

	a_one_kind: assert property (@(posedge clock) disable iff (!arst_n)
		!(wb.gr_valid && wb.spr_valid) && !(prev_wb.gr_valid && prev_wb.spr_valid))
		else $error("gr_valid and spr_valid both set");

endmodule

bind writeback_pipe exec_core_checker u_checker (.*);

//--- tests/exec_core_tb.sv
module exec_core_tb import exec_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int n_table = 21;
	localparam int n_rand = 200;

	logic clock;
	logic arst_n;
	logic issue_valid;
	exec_instr_s issue_instr;
	wb_entry_s commit;

	exec_instr_s tbl_instr[$];
	logic [data_w-1:0] tbl_exp[$];
	wb_entry_s exp_q[$];
	logic [data_w-1:0] gr_m[num_gr];
	logic [data_w-1:0] spr_m;
	logic [31:0] lfsr = 32'heb3e15bf;

	exec_core UUT (
		.clock(clock),
		.arst_n(arst_n),
		.issue_valid(issue_valid),
		.issue_instr(issue_instr),
		.commit(commit)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial begin
		#((2 + n_table + 2 * n_rand + 20) * 10);
		$display("watchdog expired before all commits were checked");
		$display("*** TEST FAILED ***");
		$fatal(1, "timeout");
	end

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic exec_instr_s mk(exec_op_e op, logic [4:0] d, logic d_sys,
		logic [4:0] a, logic a_sys, logic ui, logic [14:0] opnd);
		exec_instr_s i;
		i.opcode = op;
		i.dest = d;
		i.dest_sysreg = d_sys;
		i.a = a;
		i.a_sysreg = a_sys;
		i.use_imm = ui;
		i.operand.imm_form = opnd;
		return i;
	endfunction

	function automatic logic [14:0] reg_opnd(logic [4:0] b, logic b_sys);
		return {b, b_sys, 9'd0};
	endfunction

	function automatic logic [data_w-1:0] sys_value(logic [4:0] ptr);
		return (ptr == sysreg_spr) ? spr_m : 32'd0;
	endfunction

	// In-order reference execution
	function automatic wb_entry_s model_exec(exec_instr_s i);
		wb_entry_s e;
		logic [data_w-1:0] a;
		logic [data_w-1:0] b;
		logic [data_w-1:0] imm;
		imm = {{17{i.operand.imm_form[14]}}, i.operand.imm_form};
		a = i.a_sysreg ? sys_value(i.a) : gr_m[i.a];
		if (i.use_imm) begin
			b = imm;
		end else if (i.operand.reg_form.b_sysreg) begin
			b = sys_value(i.operand.reg_form.b);
		end else begin
			b = gr_m[i.operand.reg_form.b];
		end
		e = '0;
		e.gr_valid = 1'b1;
		e.gr_dest = i.dest;
		e.gr_dest_sysreg = i.dest_sysreg;
		case (i.opcode)
			op_add: e.gr_data = a + b;
			op_sub: e.gr_data = a - b;
			op_and: e.gr_data = a & b;
			op_or: e.gr_data = a | b;
			op_xor: e.gr_data = a ^ b;
			op_shl: e.gr_data = a << b[4:0];
			op_movs: e.gr_data = a;
			op_setsp: begin
				e.gr_valid = 1'b0;
				e.spr_valid = 1'b1;
				e.spr_data = spr_m + imm;
			end
			default: e.gr_valid = 1'b0;
		endcase
		if (e.gr_valid && !e.gr_dest_sysreg) begin
			gr_m[e.gr_dest] = e.gr_data;
		end
		if (e.spr_valid) begin
			spr_m = e.spr_data;
		end
		return e;
	endfunction

	task automatic check(string what, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("error: %0t ns %s: got %h expected %h", $time, what, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic compare_commit(wb_entry_s exp);
		check("commit gr_valid", 32'(commit.gr_valid), 32'(exp.gr_valid));
		check("commit spr_valid", 32'(commit.spr_valid), 32'(exp.spr_valid));
		if (exp.gr_valid) begin
			check("commit gr_data", commit.gr_data, exp.gr_data);
			check("commit gr_dest", 32'(commit.gr_dest), 32'(exp.gr_dest));
			check("commit gr_dest_sysreg", 32'(commit.gr_dest_sysreg), 32'(exp.gr_dest_sysreg));
		end
		if (exp.spr_valid) begin
			check("commit spr_data", commit.spr_data, exp.spr_data);
		end
	endtask

	// Commit of an issue shows up in the fourth cycle of this loop
	task automatic issue_cycle(logic v, exec_instr_s instr, wb_entry_s exp);
		@(posedge clock);
		issue_valid <= v;
		issue_instr <= instr;
		exp_q.push_back(exp);
		@(negedge clock);
		if (exp_q.size() == 4) begin
			compare_commit(exp_q.pop_front());
		end else begin
			check("early commit valid", 32'(commit.gr_valid || commit.spr_valid), 32'd0);
		end
	endtask

	task automatic add_entry(exec_instr_s instr, logic [data_w-1:0] exp);
		tbl_instr.push_back(instr);
		tbl_exp.push_back(exp);
	endtask

	initial begin
		wb_entry_s e;
		exec_instr_s ri;
		arst_n = 1'b0;
		issue_valid = 1'b0;
		issue_instr = '0;
		spr_m = '0;
		for (int r = 0; r < num_gr; r++) begin
			gr_m[r] = '0;
		end
		add_entry(mk(op_add, 5'd1, 1'b0, 5'd0, 1'b0, 1'b1, 15'd5), 32'd5);
		add_entry(mk(op_add, 5'd2, 1'b0, 5'd1, 1'b0, 1'b1, 15'd3), 32'd8);
		add_entry(mk(op_sub, 5'd3, 1'b0, 5'd2, 1'b0, 1'b0, reg_opnd(5'd1, 1'b0)), 32'd3);
		add_entry(mk(op_shl, 5'd4, 1'b0, 5'd1, 1'b0, 1'b1, 15'd2), 32'd20);
		add_entry(mk(op_add, 5'd1, 1'b0, 5'd0, 1'b0, 1'b1, 15'h7fff), 32'hffffffff);
		add_entry(mk(op_add, 5'd1, 1'b0, 5'd0, 1'b0, 1'b1, 15'd7), 32'd7);
		add_entry(mk(op_xor, 5'd5, 1'b0, 5'd1, 1'b0, 1'b1, 15'd1), 32'd6);
		add_entry(mk(op_and, 5'd6, 1'b0, 5'd5, 1'b0, 1'b0, reg_opnd(5'd3, 1'b0)), 32'd2);
		add_entry(mk(op_setsp, 5'd0, 1'b0, 5'd0, 1'b0, 1'b1, 15'd16), 32'd16);
		add_entry(mk(op_setsp, 5'd0, 1'b0, 5'd0, 1'b0, 1'b1, 15'h7ffc), 32'd12);
		add_entry(mk(op_movs, 5'd7, 1'b0, 5'd1, 1'b1, 1'b0, 15'd0), 32'd12);
		add_entry(mk(op_movs, 5'd8, 1'b0, 5'd3, 1'b1, 1'b0, 15'd0), 32'd0);
		add_entry(mk(op_add, 5'd2, 1'b1, 5'd0, 1'b0, 1'b1, 15'd9), 32'd9);
		add_entry(mk(op_add, 5'd10, 1'b0, 5'd2, 1'b0, 1'b1, 15'd0), 32'd8);
		add_entry(mk(op_or, 5'd11, 1'b0, 5'd4, 1'b0, 1'b0, reg_opnd(5'd1, 1'b0)), 32'd23);
		add_entry(mk(op_setsp, 5'd0, 1'b0, 5'd0, 1'b0, 1'b1, 15'd1), 32'd13);
		add_entry(mk(op_add, 5'd12, 1'b0, 5'd3, 1'b0, 1'b0, reg_opnd(5'd6, 1'b0)), 32'd5);
		add_entry(mk(op_movs, 5'd13, 1'b0, 5'd1, 1'b1, 1'b0, 15'd0), 32'd13);
		// SETSP base from the register file, then from prev_wb
		add_entry(mk(op_setsp, 5'd0, 1'b0, 5'd0, 1'b0, 1'b1, 15'd2), 32'd15);
		add_entry(mk(op_add, 5'd14, 1'b0, 5'd12, 1'b0, 1'b1, 15'd1), 32'd6);
		add_entry(mk(op_setsp, 5'd0, 1'b0, 5'd0, 1'b0, 1'b1, 15'd3), 32'd18);
		repeat (2) @(posedge clock);
		check("commit valid in reset", 32'(commit.gr_valid || commit.spr_valid), 32'd0);
		arst_n <= 1'b1;
		for (int i = 0; i < tbl_instr.size(); i++) begin
			e = model_exec(tbl_instr[i]);
			check("table value", e.spr_valid ? e.spr_data : e.gr_data, tbl_exp[i]);
			issue_cycle(1'b1, tbl_instr[i], e);
		end
		for (int i = 0; i < n_rand; i++) begin
			if (rand_bits(3) == 0) begin
				issue_cycle(1'b0, '0, '0);
			end
			// Narrow pointers keep hazards frequent
			ri = mk(exec_op_e'({1'b0, 3'(rand_bits(3))}), 5'(rand_bits(3)),
				rand_bits(2) == 0, 5'(rand_bits(3)), rand_bits(1) == 1,
				rand_bits(1) == 1, 15'(rand_bits(15)));
			e = model_exec(ri);
			issue_cycle(1'b1, ri, e);
		end
		repeat (4) issue_cycle(1'b0, '0, '0);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule
